// File: clint_timer.sv
// free-running mtime, writable mtimecmp and registered timer interrupt
`include "trap_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module clint_timer (
  input  logic             clock,
  input  logic             reset,
  input  logic             mtimecmp_we,
  input  logic [`XLEN-1:0] mtimecmp_wd,
  output logic             timer_irq
);

  logic [`XLEN-1:0] mtime_q;
  logic [`XLEN-1:0] mtimecmp_q;

  // one tick per cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  // all ones keeps the interrupt off until software arms it
  always_ff @(posedge clock) begin
    if (reset) begin
      mtimecmp_q <= '1;
    end else if (mtimecmp_we) begin
      mtimecmp_q <= mtimecmp_wd;
    end
  end

  // level stays high until mtimecmp moves ahead again
  always_ff @(posedge clock) begin
    if (reset) begin
      timer_irq <= 1'b0;
    end else begin
      timer_irq <= (mtime_q >= mtimecmp_q);
    end
  end

endmodule

`default_nettype wire

// File: csr_file.sv
// machine trap CSRs with software read-modify-write and trap-side updates
`include "trap_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module csr_file (
  input  logic                clock,
  input  logic                reset,
  input  csr_pkg::csr_op_e    csr_op,
  input  csr_pkg::csr_addr_e  csr_addr,
  input  logic [`XLEN-1:0]    csr_wdata,
  output logic [`XLEN-1:0]    csr_rdata,
  input  logic                soft_irq,
  input  logic                ext_irq,
  input  logic                timer_irq,
  csr_trap_if.csrs            csr
);

  import csr_pkg::*;

  logic [`XLEN-1:0] mstatus_q;
  logic [`XLEN-1:0] mie_q;
  logic [`XLEN-1:0] mtvec_q;
  logic [`XLEN-1:0] mepc_q;
  logic [`XLEN-1:0] mcause_q;
  logic [`XLEN-1:0] mtval_q;
  logic [`XLEN-1:0] mip_val;
  logic             sw_we;
  logic [`XLEN-1:0] sw_wd;

  // new value for csrrw / csrrs / csrrc
  function automatic logic [`XLEN-1:0] csr_modify(
    input csr_op_e          op,
    input logic [`XLEN-1:0] old_val,
    input logic [`XLEN-1:0] operand
  );
    logic [`XLEN-1:0] result;
    case (op)
      CSR_OP_WRITE: result = operand;
      CSR_OP_SET:   result = old_val | operand;
      CSR_OP_CLEAR: result = old_val & ~operand;
      default:      result = old_val;
    endcase
    return result;
  endfunction

  // mip follows the interrupt lines, software writes dropped
  always_comb begin
    mip_val = '0;
    mip_val[`IRQ_MSI] = soft_irq;
    mip_val[`IRQ_MTI] = timer_irq;
    mip_val[`IRQ_MEI] = ext_irq;
  end

  always_comb begin
    case (csr_addr)
      CSR_MSTATUS: csr_rdata = mstatus_q;
      CSR_MIE:     csr_rdata = mie_q;
      CSR_MTVEC:   csr_rdata = mtvec_q;
      CSR_MEPC:    csr_rdata = mepc_q;
      CSR_MCAUSE:  csr_rdata = mcause_q;
      CSR_MTVAL:   csr_rdata = mtval_q;
      CSR_MIP:     csr_rdata = mip_val;
      default:     csr_rdata = '0;
    endcase
  end

  assign sw_we = (csr_op != CSR_OP_NONE);
  assign sw_wd = csr_modify(csr_op, csr_rdata, csr_wdata);

  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus_q <= '0;
      mie_q     <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
      mtval_q   <= '0;
    end else begin
      // trap entry owns mepc, mcause and mtval
      if (csr.trap_we) begin
        mepc_q   <= csr.mepc_wd;
        mcause_q <= csr.mcause_wd;
        mtval_q  <= csr.mtval_wd;
      end else if (sw_we) begin
        if (csr_addr == CSR_MEPC) mepc_q <= sw_wd;
        if (csr_addr == CSR_MCAUSE) mcause_q <= sw_wd;
        if (csr_addr == CSR_MTVAL) mtval_q <= sw_wd;
      end

      // save MIE on entry, restore it on mret
      if (csr.trap_we) begin
        mstatus_q[MSTATUS_MPIE] <= mstatus_q[MSTATUS_MIE];
        mstatus_q[MSTATUS_MIE]  <= 1'b0;
      end else if (csr.mret_we) begin
        mstatus_q[MSTATUS_MIE]  <= mstatus_q[MSTATUS_MPIE];
        mstatus_q[MSTATUS_MPIE] <= 1'b1;
      end else if (sw_we && csr_addr == CSR_MSTATUS) begin
        mstatus_q <= sw_wd;
      end

      if (sw_we && csr_addr == CSR_MIE) mie_q <= sw_wd;
      if (sw_we && csr_addr == CSR_MTVEC) mtvec_q <= sw_wd;
    end
  end

  assign csr.mstatus = mstatus_q;
  assign csr.mtvec   = mtvec_q;
  assign csr.mepc    = mepc_q;
  assign csr.mie     = mie_q;
  assign csr.mip     = mip_val;

endmodule

`default_nettype wire

// File: csr_pkg.sv
// machine CSR address enum, CSR operation enum and mstatus bit positions
`default_nettype none

package csr_pkg;

  // machine-mode trap CSR numbers
  typedef enum logic [11:0] {
    CSR_MSTATUS = 12'h300,
    CSR_MIE     = 12'h304,
    CSR_MTVEC   = 12'h305,
    CSR_MEPC    = 12'h341,
    CSR_MCAUSE  = 12'h342,
    CSR_MTVAL   = 12'h343,
    CSR_MIP     = 12'h344
  } csr_addr_e;

  // software access kinds, as in csrrw / csrrs / csrrc
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'd0,
    CSR_OP_WRITE = 2'd1,
    CSR_OP_SET   = 2'd2,
    CSR_OP_CLEAR = 2'd3
  } csr_op_e;

  // global interrupt enable
  localparam int MSTATUS_MIE = 3;

  // enable saved on trap entry
  localparam int MSTATUS_MPIE = 7;

endpackage

`default_nettype wire

// File: csr_trap_if.sv
// CSR read values to the trap handler and trap update strobes back, with modports
`include "trap_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

interface csr_trap_if;

  // current CSR state seen by the handler
  logic [`XLEN-1:0] mstatus;
  logic [`XLEN-1:0] mtvec;
  logic [`XLEN-1:0] mepc;
  logic [`XLEN-1:0] mie;
  logic [`XLEN-1:0] mip;

  // trap entry and exit strobes
  logic             trap_we;
  logic             mret_we;

  // values written on trap entry
  logic [`XLEN-1:0] mepc_wd;
  logic [`XLEN-1:0] mcause_wd;
  logic [`XLEN-1:0] mtval_wd;

  modport csrs (
    output mstatus, mtvec, mepc, mie, mip,
    input  trap_we, mret_we, mepc_wd, mcause_wd, mtval_wd
  );

  modport handler (
    input  mstatus, mtvec, mepc, mie, mip,
    output trap_we, mret_we, mepc_wd, mcause_wd, mtval_wd
  );

endinterface

`default_nettype wire

// File: list.f
+incdir+.
csr_pkg.sv
trap_pkg.sv
csr_trap_if.sv
clint_timer.sv
csr_file.sv
trap_handler.sv
trap_top.sv
trap_sva.sv
tb_trap_top.sv

// File: tb_trap_top.sv
// testbench for the trap subsystem, driven and checked from trap_tests.txt
`include "trap_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module tb_trap_top;

  import csr_pkg::*;
  import trap_pkg::*;

  logic             clock;
  logic             reset;
  excp_vec_t        excp_flags;
  logic [`XLEN-1:0] pc;
  logic [31:0]      inst;
  logic [`XLEN-1:0] mem_addr;
  logic             mret;
  logic             soft_irq;
  logic             ext_irq;
  logic             mtimecmp_we;
  logic [`XLEN-1:0] mtimecmp_wd;
  csr_op_e          csr_op;
  csr_addr_e        csr_addr;
  logic [`XLEN-1:0] csr_wdata;
  logic [`XLEN-1:0] csr_rdata;
  logic             jump_ena;
  logic [`XLEN-1:0] jump_pc;
  logic             irq_taken;
  logic [`XLEN-1:0] cause;

  string            kind_q[$];
  logic [`XLEN-1:0] field_q[$];
  bit               load_ok = 1'b1;
  int               cycle_cnt = 0;
  int               cycle_limit = 0;
  int               err_cnt = 0;
  int               pass_cnt = 0;
  int               fail_cnt = 0;

  trap_top dut_i (
    .clock       (clock),
    .reset       (reset),
    .excp_flags  (excp_flags),
    .pc          (pc),
    .inst        (inst),
    .mem_addr    (mem_addr),
    .mret        (mret),
    .soft_irq    (soft_irq),
    .ext_irq     (ext_irq),
    .mtimecmp_we (mtimecmp_we),
    .mtimecmp_wd (mtimecmp_wd),
    .csr_op      (csr_op),
    .csr_addr    (csr_addr),
    .csr_wdata   (csr_wdata),
    .csr_rdata   (csr_rdata),
    .jump_ena    (jump_ena),
    .jump_pc     (jump_pc),
    .irq_taken   (irq_taken),
    .cause       (cause)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // run limit set once the tests are loaded
  always @(posedge clock) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic drive_idle();
    excp_flags  <= '0;
    pc          <= '0;
    inst        <= '0;
    mem_addr    <= '0;
    mret        <= 1'b0;
    soft_irq    <= 1'b0;
    ext_irq     <= 1'b0;
    mtimecmp_we <= 1'b0;
    mtimecmp_wd <= '0;
    csr_op      <= CSR_OP_NONE;
    csr_addr    <= CSR_MSTATUS;
    csr_wdata   <= '0;
  endtask

  task automatic check_val(input string name, input logic [`XLEN-1:0] got,
                           input logic [`XLEN-1:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  // lines starting with # are column notes
  task automatic load_tests();
    int               fd;
    int               n;
    string            kind;
    string            rest;
    logic [`XLEN-1:0] f [6];
    fd = $fopen("trap_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open trap_tests.txt");
      load_ok = 1'b0;
    end else begin
      while ($fscanf(fd, "%s", kind) == 1) begin
        if (kind.getc(0) == "#") begin
          n = $fgets(rest, fd);
        end else begin
          n = $fscanf(fd, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
          if (n != 6) begin
            $display("malformed test line of kind %s", kind);
            load_ok = 1'b0;
          end else begin
            kind_q.push_back(kind);
            for (int k = 0; k < 6; k++) field_q.push_back(f[k]);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_test(input int t);
    string            kind;
    logic [`XLEN-1:0] f [6];
    int               errs_before;
    int               waited;
    bit               seen;
    kind = kind_q[t];
    for (int k = 0; k < 6; k++) f[k] = field_q[t * 6 + k];
    errs_before = err_cnt;
    @(posedge clock);
    drive_idle();
    if (kind == "csrw") begin
      csr_addr  <= csr_addr_e'(f[0][11:0]);
      csr_op    <= csr_op_e'(f[1][1:0]);
      csr_wdata <= f[2];
    end else if (kind == "rd") begin
      csr_addr <= csr_addr_e'(f[0][11:0]);
      @(negedge clock);
      check_val("csr_rdata", csr_rdata, f[4]);
    end else if (kind == "exc" || kind == "irq" || kind == "mret") begin
      if (kind == "exc") begin
        excp_flags <= f[0][`EXCP_W-1:0];
        pc         <= f[1];
        inst       <= f[2][31:0];
        mem_addr   <= f[3];
      end else if (kind == "irq") begin
        soft_irq <= f[0][0];
        ext_irq  <= f[1][0];
        pc       <= f[2];
      end else begin
        mret <= 1'b1;
      end
      // handler is combinational, result in the same cycle
      @(negedge clock);
      check_val("jump_ena", jump_ena, 1);
      check_val("jump_pc", jump_pc, f[4]);
      if (kind != "mret") begin
        check_val("cause", cause, f[5]);
        check_val("irq_taken", irq_taken, (kind == "irq"));
      end
    end else if (kind == "tmr") begin
      mtimecmp_we <= 1'b1;
      mtimecmp_wd <= cycle_cnt + f[0];
      seen = 1'b0;
      waited = 0;
      while (!seen && waited < f[1]) begin
        @(negedge clock);
        if (jump_ena === 1'b1) begin
          seen = 1'b1;
        end else begin
          @(posedge clock);
          drive_idle();
          waited++;
        end
      end
      if (seen != f[2][0]) begin
        $display("timer test: jump %s", seen ? "occurred although mie bit 7 is clear"
                                             : "missing within the wait window");
        err_cnt++;
      end else if (seen) begin
        check_val("jump_pc", jump_pc, f[4]);
        check_val("cause", cause, f[5]);
      end
      // disarm so the level drops before the next test
      @(posedge clock);
      drive_idle();
      mtimecmp_we <= 1'b1;
      mtimecmp_wd <= '1;
      @(posedge clock);
      drive_idle();
      repeat (2) @(posedge clock);
    end else begin
      $display("unknown test kind %s", kind);
      err_cnt++;
    end
    if (err_cnt == errs_before) pass_cnt++;
    else fail_cnt++;
    $display("test %0d %s %s", t, kind, (err_cnt == errs_before) ? "ok" : "wrong");
  endtask

  initial begin
    reset = 1'b1;
    drive_idle();
    load_tests();
    cycle_limit = 20 * kind_q.size() + 200;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    for (int t = 0; t < kind_q.size(); t++) run_test(t);
    $display("tests %0d passed %0d failed %0d", kind_q.size(), pass_cnt, fail_cnt);
    if (dut_i.sva_i.assert_errs != 0) begin
      $display("%0d assertion failures during the run", dut_i.sva_i.assert_errs);
    end
    if (err_cnt == 0 && dut_i.sva_i.assert_errs == 0 && load_ok && kind_q.size() > 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: trap_cfg.svh
// register width, exception flag count and interrupt bit positions
`ifndef TRAP_CFG_SVH
`define TRAP_CFG_SVH

`default_nettype none

// machine register width
`define XLEN 64

// one flag per exception code, codes 0 to 15
`define EXCP_W 16

// interrupt bit positions shared by mip and mie
`define IRQ_MSI 3
`define IRQ_MTI 7
`define IRQ_MEI 11

// width of the cause code field
`define CAUSE_W 6

// mtvec mode encodings
`define MTVEC_DIRECT 2'b00
`define MTVEC_VECTORED 2'b01

`default_nettype wire

`endif

// File: trap_handler.sv
// trap cause decode, priority select, jump target and trap CSR update values
`include "trap_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module trap_handler (
  input  trap_pkg::excp_vec_t excp_flags,
  input  logic [`XLEN-1:0]    pc,
  input  logic [31:0]         inst,
  input  logic [`XLEN-1:0]    mem_addr,
  input  logic                mret,
  csr_trap_if.handler         csr,
  output logic                jump_ena,
  output logic [`XLEN-1:0]    jump_pc,
  output logic                irq_taken,
  output logic [`XLEN-1:0]    cause
);

  import trap_pkg::*;
  import csr_pkg::*;

  logic [`XLEN-1:0]    irq_pend;
  irq_cause_e          irq_code;
  logic                excp_any;
  logic [`CAUSE_W-1:0] excp_code;
  logic                trap_enter;
  logic [`XLEN-1:0]    mtval_val;
  logic [`XLEN-1:0]    cause_val;
  logic [`XLEN-1:0]    mtvec_base;
  logic [`XLEN-1:0]    enter_pc;

  // enabled and pending, gated by global MIE
  assign irq_pend  = csr.mstatus[MSTATUS_MIE] ? (csr.mie & csr.mip) : '0;
  assign irq_taken = irq_pend[`IRQ_MEI] | irq_pend[`IRQ_MSI] | irq_pend[`IRQ_MTI];

  // fixed order mei, msi, mti
  always_comb begin
    if (irq_pend[`IRQ_MEI]) begin
      irq_code = IRQ_CODE_MEI;
    end else if (irq_pend[`IRQ_MSI]) begin
      irq_code = IRQ_CODE_MSI;
    end else begin
      irq_code = IRQ_CODE_MTI;
    end
  end

  // lowest set flag wins
  assign excp_any = |excp_flags;
  always_comb begin
    excp_code = '0;
    for (int i = `EXCP_W - 1; i >= 0; i--) begin
      if (excp_flags[i]) begin
        excp_code = i[`CAUSE_W-1:0];
      end
    end
  end

  assign trap_enter = irq_taken | excp_any;

  // fault address or instruction by exception class
  always_comb begin
    mtval_val = '0;
    if (!irq_taken) begin
      case (excp_code)
        EXC_INST_MISALIGN, EXC_INST_ACCESS, EXC_INST_PAGE: begin
          mtval_val = pc;
        end
        EXC_ILLEGAL_INST: begin
          mtval_val = {{(`XLEN - 32){1'b0}}, inst};
        end
        EXC_LOAD_MISALIGN, EXC_LOAD_ACCESS, EXC_LOAD_PAGE,
        EXC_STORE_MISALIGN, EXC_STORE_ACCESS, EXC_STORE_PAGE: begin
          mtval_val = mem_addr;
        end
        default: begin
          mtval_val = '0;
        end
      endcase
    end
  end

  // interrupt flag in the top bit
  always_comb begin
    cause_val = '0;
    cause_val[`CAUSE_W-1:0] = irq_taken ? irq_code : excp_code;
    cause_val[`XLEN-1] = irq_taken;
  end

  // vectored mode only offsets interrupts
  assign mtvec_base = {csr.mtvec[`XLEN-1:2], 2'b00};
  always_comb begin
    if (csr.mtvec[1:0] == `MTVEC_VECTORED && irq_taken) begin
      enter_pc = mtvec_base + {{(`XLEN - `CAUSE_W - 2){1'b0}}, irq_code, 2'b00};
    end else begin
      enter_pc = mtvec_base;
    end
  end

  // trap entry has priority over a return in the same cycle
  assign jump_ena = trap_enter | mret;
  assign jump_pc  = trap_enter ? enter_pc : csr.mepc;
  assign cause    = trap_enter ? cause_val : '0;

  assign csr.trap_we   = trap_enter;
  assign csr.mret_we   = mret & ~trap_enter;
  assign csr.mepc_wd   = pc;
  assign csr.mcause_wd = cause_val;
  assign csr.mtval_wd  = mtval_val;

endmodule

`default_nettype wire

// File: trap_pkg.sv
// exception cause enum, interrupt cause enum and exception flag vector type
`include "trap_cfg.svh"

`default_nettype none

package trap_pkg;

  // synchronous exception codes
  typedef enum logic [`CAUSE_W-1:0] {
    EXC_INST_MISALIGN  = 6'd0,
    EXC_INST_ACCESS    = 6'd1,
    EXC_ILLEGAL_INST   = 6'd2,
    EXC_BREAKPOINT     = 6'd3,
    EXC_LOAD_MISALIGN  = 6'd4,
    EXC_LOAD_ACCESS    = 6'd5,
    EXC_STORE_MISALIGN = 6'd6,
    EXC_STORE_ACCESS   = 6'd7,
    EXC_ECALL_M        = 6'd11,
    EXC_INST_PAGE      = 6'd12,
    EXC_LOAD_PAGE      = 6'd13,
    EXC_STORE_PAGE     = 6'd15
  } excp_cause_e;

  // machine interrupt codes, same as the mip bit index
  typedef enum logic [`CAUSE_W-1:0] {
    IRQ_CODE_MSI = 6'd3,
    IRQ_CODE_MTI = 6'd7,
    IRQ_CODE_MEI = 6'd11
  } irq_cause_e;

  // bit n set means exception code n is raised
  typedef logic [`EXCP_W-1:0] excp_vec_t;

endpackage

`default_nettype wire

// File: trap_sva.sv
// concurrent checks on jump enable, trap entry mepc and MIE, bound into trap_top
`include "trap_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module trap_sva (
  input logic             clock,
  input logic             reset,
  input logic [`XLEN-1:0] pc,
  input logic             jump_ena,
  input logic             trap_we,
  input logic [`XLEN-1:0] mepc,
  input logic [`XLEN-1:0] mstatus
);

  import csr_pkg::*;

  // number of failed properties so far
  int assert_errs = 0;

  // CSRs are cleared, so no redirect while held in reset
  reset_no_jump: assert property (@(posedge clock) reset |=> !jump_ena)
    else begin
      $error("jump_ena high during reset");
      assert_errs++;
    end

  // trap entry captures the faulting pc
  mepc_capture: assert property (@(posedge clock) disable iff (reset)
    trap_we |=> (mepc == $past(pc)))
    else begin
      $error("mepc does not hold the trapping pc");
      assert_errs++;
    end

  // global enable drops on entry
  mie_cleared: assert property (@(posedge clock) disable iff (reset)
    trap_we |=> !mstatus[MSTATUS_MIE])
    else begin
      $error("mstatus.MIE still set after trap entry");
      assert_errs++;
    end

endmodule

bind trap_top trap_sva sva_i (
  .clock    (clock),
  .reset    (reset),
  .pc       (pc),
  .jump_ena (jump_ena),
  .trap_we  (trap_bus.trap_we),
  .mepc     (trap_bus.mepc),
  .mstatus  (trap_bus.mstatus)
);

`default_nettype wire

// File: trap_tests.txt
# kind f0 f1 f2 f3 f4 f5, all hex, f4 and f5 hold expected values
# csrw addr op data | rd addr - - - value | exc flags pc inst addr jump cause | irq msi mei pc - jump cause | mret - - - - jump | tmr delta window hit - jump cause
csrw 305 1 80000100 0 0 0
rd   305 0 0 0 80000100 0
exc  0004 1000 deadbeef 2000 80000100 2
rd   342 0 0 0 2 0
rd   341 0 0 0 1000 0
rd   343 0 0 0 deadbeef 0
exc  0030 1004 00000013 3003 80000100 4
rd   343 0 0 0 3003 0
csrw 305 2 1 0 0 0
rd   305 0 0 0 80000101 0
csrw 304 1 888 0 0 0
csrw 304 3 80 0 0 0
rd   304 0 0 0 808 0
csrw 300 2 8 0 0 0
irq  0 1 2000 0 8000012c 800000000000000b
rd   300 0 0 0 80 0
mret 0 0 0 0 2000 0
rd   300 0 0 0 88 0
tmr  4 c 0 0 0 0
csrw 304 2 80 0 0 0
tmr  4 c 1 0 8000011c 8000000000000007

// File: trap_top.sv
// trap subsystem top with timer, machine CSR file and trap handler
`include "trap_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module trap_top (
  input  logic                clock,
  input  logic                reset,
  input  trap_pkg::excp_vec_t excp_flags,
  input  logic [`XLEN-1:0]    pc,
  input  logic [31:0]         inst,
  input  logic [`XLEN-1:0]    mem_addr,
  input  logic                mret,
  input  logic                soft_irq,
  input  logic                ext_irq,
  input  logic                mtimecmp_we,
  input  logic [`XLEN-1:0]    mtimecmp_wd,
  input  csr_pkg::csr_op_e    csr_op,
  input  csr_pkg::csr_addr_e  csr_addr,
  input  logic [`XLEN-1:0]    csr_wdata,
  output logic [`XLEN-1:0]    csr_rdata,
  output logic                jump_ena,
  output logic [`XLEN-1:0]    jump_pc,
  output logic                irq_taken,
  output logic [`XLEN-1:0]    cause
);

  logic timer_irq;

  // CSR state out, trap updates in
  csr_trap_if trap_bus ();

  clint_timer timer_i (
    .clock       (clock),
    .reset       (reset),
    .mtimecmp_we (mtimecmp_we),
    .mtimecmp_wd (mtimecmp_wd),
    .timer_irq   (timer_irq)
  );

  csr_file csrs_i (
    .clock     (clock),
    .reset     (reset),
    .csr_op    (csr_op),
    .csr_addr  (csr_addr),
    .csr_wdata (csr_wdata),
    .csr_rdata (csr_rdata),
    .soft_irq  (soft_irq),
    .ext_irq   (ext_irq),
    .timer_irq (timer_irq),
    .csr       (trap_bus.csrs)
  );

  trap_handler handler_i (
    .excp_flags (excp_flags),
    .pc         (pc),
    .inst       (inst),
    .mem_addr   (mem_addr),
    .mret       (mret),
    .csr        (trap_bus.handler),
    .jump_ena   (jump_ena),
    .jump_pc    (jump_pc),
    .irq_taken  (irq_taken),
    .cause      (cause)
  );

endmodule

`default_nettype wire
